//--- logic/rv_macros.svh
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// Data path width.
`define XLEN 32

// Instruction word width.
`define INST_LEN 32

// Register index width, giving a 32-entry register file.
`define REG_IDX_W 5

`endif

//--- logic/rv_pkg.sv
package rv_pkg;

  // Register-type field layout. The I, U and J immediates are also cut from these fields.
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fields_t;

  // Branch and store layout, with the immediate split around the register fields.
  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } bs_fields_t;

  typedef union packed {
    r_fields_t  r;
    bs_fields_t bs;
  } inst_u;

  typedef enum logic [3:0] {
    alu_add    = 4'd0,
    alu_sub    = 4'd1,
    alu_sll    = 4'd2,
    alu_slt    = 4'd3,
    alu_sltu   = 4'd4,
    alu_xor    = 4'd5,
    alu_srl    = 4'd6,
    alu_sra    = 4'd7,
    alu_or     = 4'd8,
    alu_and    = 4'd9,
    alu_pass_b = 4'd10
  } alu_op_e;

  typedef enum logic {
    src1_rs1 = 1'b0,
    src1_pc  = 1'b1
  } src1_sel_e;

  typedef enum logic [1:0] {
    src2_rs2  = 2'd0,
    src2_imm  = 2'd1,
    src2_four = 2'd2
  } src2_sel_e;

endpackage

//--- logic/id_ex_if.sv
`timescale 1ns/1ns
`include "rv_macros.svh"

interface id_ex_if (
  input logic clk
);

  logic                      valid;
  logic [`XLEN-1:0]          pc;
  logic [`INST_LEN-1:0]      instr;
  logic [`XLEN-1:0]          rs1_data;
  logic [`XLEN-1:0]          rs2_data;
  logic [`XLEN-1:0]          imm;
  rv_pkg::alu_op_e           alu_op;
  rv_pkg::src1_sel_e         src1_sel;
  rv_pkg::src2_sel_e         src2_sel;
  logic                      is_jal;
  logic                      is_jalr;
  logic                      is_brc;
  logic [2:0]                funct3;
  logic                      wb_en;
  logic [`REG_IDX_W-1:0]     rd_idx;
  logic                      trap;

  modport source (
    output valid, pc, instr, rs1_data, rs2_data, imm, alu_op, src1_sel, src2_sel,
           is_jal, is_jalr, is_brc, funct3, wb_en, rd_idx, trap
  );

  modport sink (
    input valid, pc, instr, rs1_data, rs2_data, imm, alu_op, src1_sel, src2_sel,
          is_jal, is_jalr, is_brc, funct3, wb_en, rd_idx, trap
  );

  modport reg_out (
    output valid, pc, instr, rs1_data, rs2_data, imm, alu_op, src1_sel, src2_sel,
           is_jal, is_jalr, is_brc, funct3, wb_en, rd_idx, trap
  );

  modport exec (
    input clk, valid, pc, instr, rs1_data, rs2_data, imm, alu_op, src1_sel, src2_sel,
          is_jal, is_jalr, is_brc, funct3, wb_en, rd_idx, trap
  );

endinterface

//--- logic/reg_file.sv
`timescale 1ns/1ns
`include "rv_macros.svh"

module reg_file (
  input  logic                  clk,
  input  logic                  reset_i,
  input  logic                  we_i,
  input  logic [`REG_IDX_W-1:0] waddr_i,
  input  logic [`XLEN-1:0]      wdata_i,
  input  logic [`REG_IDX_W-1:0] raddr1_i,
  input  logic [`REG_IDX_W-1:0] raddr2_i,
  output logic [`XLEN-1:0]      rdata1_o,
  output logic [`XLEN-1:0]      rdata2_o
);

  localparam int n_regs = 1 << `REG_IDX_W;

  logic [`XLEN-1:0] regs [n_regs];
  logic             wr_live;

  assign wr_live = we_i && (waddr_i != '0);

  always_ff @(posedge clk) begin
    if (reset_i) begin
      for (int i = 0; i < n_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_live) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // A write landing on the same index this cycle is forwarded to the reader.
  assign rdata1_o = (raddr1_i == '0) ? '0 :
                    (wr_live && waddr_i == raddr1_i) ? wdata_i : regs[raddr1_i];
  assign rdata2_o = (raddr2_i == '0) ? '0 :
                    (wr_live && waddr_i == raddr2_i) ? wdata_i : regs[raddr2_i];

  x0_stays_zero: assert property (@(posedge clk) regs[0] == '0)
    else $error("x0 storage holds a nonzero value");

endmodule

//--- logic/inst_decoder.sv
`timescale 1ns/1ns
`include "rv_macros.svh"

module inst_decoder (
  input  rv_pkg::inst_u     instr_i,
  output logic [`XLEN-1:0]  imm_o,
  output rv_pkg::alu_op_e   alu_op_o,
  output rv_pkg::src1_sel_e src1_sel_o,
  output rv_pkg::src2_sel_e src2_sel_o,
  output logic              is_jal_o,
  output logic              is_jalr_o,
  output logic              is_brc_o,
  output logic              wb_en_o,
  output logic              trap_o
);

  localparam logic [6:0] opc_op     = 7'b0110011;
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_lui    = 7'b0110111;
  localparam logic [6:0] opc_auipc  = 7'b0010111;
  localparam logic [6:0] opc_jal    = 7'b1101111;
  localparam logic [6:0] opc_jalr   = 7'b1100111;
  localparam logic [6:0] opc_branch = 7'b1100011;

  logic [`XLEN-1:0] imm_i_w;
  logic [`XLEN-1:0] imm_u_w;
  logic [`XLEN-1:0] imm_j_w;
  logic [`XLEN-1:0] imm_b_w;

  // Register ops use bit 30 for sub, immediate ops only for the arithmetic shift.
  function automatic rv_pkg::alu_op_e alu_decode(input logic [2:0] funct3,
                                                 input logic       bit30,
                                                 input logic       is_reg);
    case (funct3)
      3'b000:  return (is_reg && bit30) ? rv_pkg::alu_sub : rv_pkg::alu_add;
      3'b001:  return rv_pkg::alu_sll;
      3'b010:  return rv_pkg::alu_slt;
      3'b011:  return rv_pkg::alu_sltu;
      3'b100:  return rv_pkg::alu_xor;
      3'b101:  return bit30 ? rv_pkg::alu_sra : rv_pkg::alu_srl;
      3'b110:  return rv_pkg::alu_or;
      default: return rv_pkg::alu_and;
    endcase
  endfunction

  assign imm_i_w = {{(`XLEN-12){instr_i.r.funct7[6]}}, instr_i.r.funct7, instr_i.r.rs2};
  assign imm_u_w = {instr_i.r.funct7, instr_i.r.rs2, instr_i.r.rs1, instr_i.r.funct3, 12'b0};
  assign imm_j_w = {{(`XLEN-20){instr_i.r.funct7[6]}}, instr_i.r.rs1, instr_i.r.funct3,
                    instr_i.r.rs2[0], instr_i.r.funct7[5:0], instr_i.r.rs2[4:1], 1'b0};
  assign imm_b_w = {{(`XLEN-12){instr_i.bs.imm_hi[6]}}, instr_i.bs.imm_lo[0],
                    instr_i.bs.imm_hi[5:0], instr_i.bs.imm_lo[4:1], 1'b0};

  always_comb begin
    imm_o      = '0;
    alu_op_o   = rv_pkg::alu_add;
    src1_sel_o = rv_pkg::src1_rs1;
    src2_sel_o = rv_pkg::src2_rs2;
    is_jal_o   = 1'b0;
    is_jalr_o  = 1'b0;
    is_brc_o   = 1'b0;
    wb_en_o    = 1'b0;
    trap_o     = 1'b0;
    case (instr_i.r.opcode)
      opc_op: begin
        alu_op_o = alu_decode(instr_i.r.funct3, instr_i.r.funct7[5], 1'b1);
        wb_en_o  = 1'b1;
      end
      opc_op_imm: begin
        imm_o      = imm_i_w;
        alu_op_o   = alu_decode(instr_i.r.funct3, instr_i.r.funct7[5], 1'b0);
        src2_sel_o = rv_pkg::src2_imm;
        wb_en_o    = 1'b1;
      end
      opc_lui: begin
        imm_o      = imm_u_w;
        alu_op_o   = rv_pkg::alu_pass_b;
        src2_sel_o = rv_pkg::src2_imm;
        wb_en_o    = 1'b1;
      end
      opc_auipc: begin
        imm_o      = imm_u_w;
        src1_sel_o = rv_pkg::src1_pc;
        src2_sel_o = rv_pkg::src2_imm;
        wb_en_o    = 1'b1;
      end
      // Jumps write the link address pc + 4, the immediate only feeds the target.
      opc_jal: begin
        imm_o      = imm_j_w;
        src1_sel_o = rv_pkg::src1_pc;
        src2_sel_o = rv_pkg::src2_four;
        is_jal_o   = 1'b1;
        wb_en_o    = 1'b1;
      end
      opc_jalr: begin
        imm_o      = imm_i_w;
        src1_sel_o = rv_pkg::src1_pc;
        src2_sel_o = rv_pkg::src2_four;
        is_jalr_o  = 1'b1;
        wb_en_o    = 1'b1;
      end
      opc_branch: begin
        imm_o    = imm_b_w;
        is_brc_o = 1'b1;
      end
      default: begin
        trap_o = 1'b1;
      end
    endcase
  end

endmodule

//--- logic/ex_reg.sv
`timescale 1ns/1ns

module ex_reg (
  input  logic      clk,
  input  logic      reset_i,
  input  logic      stall_i,
  input  logic      flush_i,
  id_ex_if.sink     d_if,
  id_ex_if.reg_out  q_if
);

  always_ff @(posedge clk) begin
    if (reset_i) begin
      q_if.valid    <= 1'b0;
      q_if.pc       <= '0;
      q_if.instr    <= '0;
      q_if.rs1_data <= '0;
      q_if.rs2_data <= '0;
      q_if.imm      <= '0;
      q_if.alu_op   <= rv_pkg::alu_add;
      q_if.src1_sel <= rv_pkg::src1_rs1;
      q_if.src2_sel <= rv_pkg::src2_rs2;
      q_if.is_jal   <= 1'b0;
      q_if.is_jalr  <= 1'b0;
      q_if.is_brc   <= 1'b0;
      q_if.funct3   <= '0;
      q_if.wb_en    <= 1'b0;
      q_if.rd_idx   <= '0;
      q_if.trap     <= 1'b0;
    end else if (!stall_i) begin
      // Flush kills only the fields that can change machine state.
      q_if.valid    <= flush_i ? 1'b0 : d_if.valid;
      q_if.pc       <= flush_i ? '0   : d_if.pc;
      q_if.instr    <= flush_i ? '0   : d_if.instr;
      q_if.is_jal   <= flush_i ? 1'b0 : d_if.is_jal;
      q_if.is_jalr  <= flush_i ? 1'b0 : d_if.is_jalr;
      q_if.is_brc   <= flush_i ? 1'b0 : d_if.is_brc;
      q_if.wb_en    <= flush_i ? 1'b0 : d_if.wb_en;
      q_if.trap     <= flush_i ? 1'b0 : d_if.trap;
      q_if.rs1_data <= d_if.rs1_data;
      q_if.rs2_data <= d_if.rs2_data;
      q_if.imm      <= d_if.imm;
      q_if.alu_op   <= d_if.alu_op;
      q_if.src1_sel <= d_if.src1_sel;
      q_if.src2_sel <= d_if.src2_sel;
      q_if.funct3   <= d_if.funct3;
      q_if.rd_idx   <= d_if.rd_idx;
    end
  end

  flush_kills_valid: assert property (
    @(posedge clk) disable iff (reset_i) (flush_i && !stall_i) |=> !q_if.valid
  ) else $error("valid survived an unstalled flush");

endmodule

//--- logic/ex_unit.sv
`timescale 1ns/1ns
`include "rv_macros.svh"

module ex_unit (
  id_ex_if.exec            e_if,
  output logic [`XLEN-1:0] alu_result_o,
  output logic             br_taken_o,
  output logic [`XLEN-1:0] target_o
);

  localparam int shamt_w = $clog2(`XLEN);

  logic [`XLEN-1:0]   op_a;
  logic [`XLEN-1:0]   op_b;
  logic [shamt_w-1:0] shamt;
  logic               rs_eq;
  logic               rs_lt;
  logic               rs_ltu;
  logic               cond;
  logic [`XLEN-1:0]   jalr_sum;

  assign op_a = (e_if.src1_sel == rv_pkg::src1_pc) ? e_if.pc : e_if.rs1_data;

  always_comb begin
    case (e_if.src2_sel)
      rv_pkg::src2_imm:  op_b = e_if.imm;
      rv_pkg::src2_four: op_b = `XLEN'd4;
      default:           op_b = e_if.rs2_data;
    endcase
  end

  assign shamt = op_b[shamt_w-1:0];

  always_comb begin
    case (e_if.alu_op)
      rv_pkg::alu_add:    alu_result_o = op_a + op_b;
      rv_pkg::alu_sub:    alu_result_o = op_a - op_b;
      rv_pkg::alu_sll:    alu_result_o = op_a << shamt;
      rv_pkg::alu_slt:    alu_result_o = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      rv_pkg::alu_sltu:   alu_result_o = {{(`XLEN-1){1'b0}}, op_a < op_b};
      rv_pkg::alu_xor:    alu_result_o = op_a ^ op_b;
      rv_pkg::alu_srl:    alu_result_o = op_a >> shamt;
      rv_pkg::alu_sra:    alu_result_o = $unsigned($signed(op_a) >>> shamt);
      rv_pkg::alu_or:     alu_result_o = op_a | op_b;
      rv_pkg::alu_and:    alu_result_o = op_a & op_b;
      rv_pkg::alu_pass_b: alu_result_o = op_b;
      default:            alu_result_o = '0;
    endcase
  end

  // Branches always compare the two register operands, never the ALU inputs.
  assign rs_eq  = e_if.rs1_data == e_if.rs2_data;
  assign rs_lt  = $signed(e_if.rs1_data) < $signed(e_if.rs2_data);
  assign rs_ltu = e_if.rs1_data < e_if.rs2_data;

  always_comb begin
    case (e_if.funct3)
      3'b000:  cond = rs_eq;
      3'b001:  cond = !rs_eq;
      3'b100:  cond = rs_lt;
      3'b101:  cond = !rs_lt;
      3'b110:  cond = rs_ltu;
      3'b111:  cond = !rs_ltu;
      default: cond = 1'b0;
    endcase
  end

  assign br_taken_o = e_if.valid && (e_if.is_jal || e_if.is_jalr || (e_if.is_brc && cond));

  assign jalr_sum = e_if.rs1_data + e_if.imm;
  assign target_o = e_if.is_jalr ? {jalr_sum[`XLEN-1:1], 1'b0} : e_if.pc + e_if.imm;

  taken_needs_valid: assert property (
    @(posedge e_if.clk) br_taken_o |-> e_if.valid && (e_if.is_jal || e_if.is_jalr || e_if.is_brc)
  ) else $error("branch taken without a valid control transfer");

endmodule

//--- logic/id_ex_top.sv
`timescale 1ns/1ns
`include "rv_macros.svh"

module id_ex_top (
  input  logic                  clk,
  input  logic                  reset_i,
  input  logic                  inst_valid_i,
  input  logic [`XLEN-1:0]      pc_i,
  input  logic [`INST_LEN-1:0]  instr_i,
  input  logic                  stall_i,
  input  logic                  flush_i,
  input  logic                  wb_en_i,
  input  logic [`REG_IDX_W-1:0] wb_idx_i,
  input  logic [`XLEN-1:0]      wb_data_i,
  output logic                  ex_valid_o,
  output logic [`XLEN-1:0]      alu_result_o,
  output logic                  br_taken_o,
  output logic [`XLEN-1:0]      target_o,
  output logic                  wb_en_o,
  output logic [`REG_IDX_W-1:0] rd_idx_o,
  output logic                  trap_o
);

  rv_pkg::inst_u instr_w;

  id_ex_if d_if (.clk(clk));
  id_ex_if q_if (.clk(clk));

  assign instr_w     = instr_i;
  assign d_if.valid  = inst_valid_i;
  assign d_if.pc     = pc_i;
  assign d_if.instr  = instr_i;
  assign d_if.funct3 = instr_w.r.funct3;
  assign d_if.rd_idx = instr_w.r.rd;

  reg_file u_reg_file (
    .clk      (clk),
    .reset_i  (reset_i),
    .we_i     (wb_en_i),
    .waddr_i  (wb_idx_i),
    .wdata_i  (wb_data_i),
    .raddr1_i (instr_w.r.rs1),
    .raddr2_i (instr_w.r.rs2),
    .rdata1_o (d_if.rs1_data),
    .rdata2_o (d_if.rs2_data)
  );

  inst_decoder u_inst_decoder (
    .instr_i    (instr_w),
    .imm_o      (d_if.imm),
    .alu_op_o   (d_if.alu_op),
    .src1_sel_o (d_if.src1_sel),
    .src2_sel_o (d_if.src2_sel),
    .is_jal_o   (d_if.is_jal),
    .is_jalr_o  (d_if.is_jalr),
    .is_brc_o   (d_if.is_brc),
    .wb_en_o    (d_if.wb_en),
    .trap_o     (d_if.trap)
  );

  ex_reg u_ex_reg (
    .clk     (clk),
    .reset_i (reset_i),
    .stall_i (stall_i),
    .flush_i (flush_i),
    .d_if    (d_if.sink),
    .q_if    (q_if.reg_out)
  );

  ex_unit u_ex_unit (
    .e_if         (q_if.exec),
    .alu_result_o (alu_result_o),
    .br_taken_o   (br_taken_o),
    .target_o     (target_o)
  );

  assign ex_valid_o = q_if.valid;
  assign wb_en_o    = q_if.wb_en;
  assign rd_idx_o   = q_if.rd_idx;
  assign trap_o     = q_if.trap;

endmodule

//--- dv/id_ex_tb.sv
`timescale 1ns/1ns
`include "rv_macros.svh"

module id_ex_tb;

  localparam logic [6:0] opc_op     = 7'b0110011;
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_lui    = 7'b0110111;
  localparam logic [6:0] opc_auipc  = 7'b0010111;
  localparam logic [6:0] opc_jal    = 7'b1101111;
  localparam logic [6:0] opc_jalr   = 7'b1100111;
  localparam logic [6:0] opc_load   = 7'b0000011;

  // About 46 instructions, each with up to two preload writes and two issue cycles.
  localparam int instr_count  = 50;
  localparam int cycles_each  = 6;
  localparam int extra_cycles = 40;
  localparam int timeout_ns   = (instr_count * cycles_each + extra_cycles) * 4;

  logic                  clk;
  logic                  reset_i;
  logic                  inst_valid_i;
  logic [`XLEN-1:0]      pc_i;
  logic [`INST_LEN-1:0]  instr_i;
  logic                  stall_i;
  logic                  flush_i;
  logic                  wb_en_i;
  logic [`REG_IDX_W-1:0] wb_idx_i;
  logic [`XLEN-1:0]      wb_data_i;
  logic                  ex_valid_o;
  logic [`XLEN-1:0]      alu_result_o;
  logic                  br_taken_o;
  logic [`XLEN-1:0]      target_o;
  logic                  wb_en_o;
  logic [`REG_IDX_W-1:0] rd_idx_o;
  logic                  trap_o;

  logic [`XLEN-1:0] shadow [32];
  logic [31:0]      lcg_state;
  int               test_errs;
  int               tests_passed;
  int               tests_failed;

  id_ex_top u_id_ex_top (
    .clk          (clk),
    .reset_i      (reset_i),
    .inst_valid_i (inst_valid_i),
    .pc_i         (pc_i),
    .instr_i      (instr_i),
    .stall_i      (stall_i),
    .flush_i      (flush_i),
    .wb_en_i      (wb_en_i),
    .wb_idx_i     (wb_idx_i),
    .wb_data_i    (wb_data_i),
    .ex_valid_o   (ex_valid_o),
    .alu_result_o (alu_result_o),
    .br_taken_o   (br_taken_o),
    .target_o     (target_o),
    .wb_en_o      (wb_en_o),
    .rd_idx_o     (rd_idx_o),
    .trap_o       (trap_o)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [6:0] opc);
    rv_pkg::inst_u w;
    w.r.funct7 = f7;
    w.r.rs2    = rs2;
    w.r.rs1    = rs1;
    w.r.funct3 = f3;
    w.r.rd     = rd;
    w.r.opcode = opc;
    return w;
  endfunction

  // Branch offsets are scattered over both immediate pieces of the word.
  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    rv_pkg::inst_u w;
    w.bs.imm_hi = {imm[12], imm[10:5]};
    w.bs.rs2    = rs2;
    w.bs.rs1    = rs1;
    w.bs.funct3 = f3;
    w.bs.imm_lo = {imm[4:1], imm[11]};
    w.bs.opcode = 7'b1100011;
    return w;
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc_jal};
  endfunction

  function automatic logic [31:0] sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  function automatic logic [31:0] sext13(input logic [12:0] v);
    return {{19{v[12]}}, v};
  endfunction

  function automatic logic [31:0] sext21(input logic [20:0] v);
    return {{11{v[20]}}, v};
  endfunction

  // Signed order is unsigned order with the sign bits flipped.
  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return {31'b0, (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)};
      3'd3: return {31'b0, a < b};
      3'd4: return a ^ b;
      3'd5: begin
        if (alt && a[31]) begin
          return (a >> b[4:0]) | ~(32'hffff_ffff >> b[4:0]);
        end
        return a >> b[4:0];
      end
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic br_ref(input logic [2:0] f3, input logic [31:0] a,
                                  input logic [31:0] b);
    logic lt_s;
    logic lt_u;
    lt_s = (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
    lt_u = a < b;
    case (f3)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return lt_s;
      3'd5: return !lt_s;
      3'd6: return lt_u;
      default: return !lt_u;
    endcase
  endfunction

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("Fail at %0t ns: %s expected %h, got %h", $time, name, exp, act);
      test_errs++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("Fail at %0t ns: %s expected %b, got %b", $time, name, exp, act);
      test_errs++;
    end
  endtask

  task automatic end_test(input string name);
    if (test_errs == 0) begin
      tests_passed++;
      $display("%s: ok", name);
    end else begin
      tests_failed++;
      $display("%s: %0d mismatches", name, test_errs);
    end
    test_errs = 0;
  endtask

  task automatic write_reg(input logic [4:0] idx, input logic [31:0] data);
    @(posedge clk);
    wb_en_i   <= 1'b1;
    wb_idx_i  <= idx;
    wb_data_i <= data;
    @(posedge clk);
    wb_en_i <= 1'b0;
    if (idx != 5'd0) begin
      shadow[idx] = data;
    end
  endtask

  // Strobes one instruction, optionally with a flush or a writeback in the same cycle.
  task automatic issue(input logic [31:0] ins, input logic [31:0] pc, input logic do_flush,
                       input logic do_wb, input logic [4:0] widx, input logic [31:0] wdata);
    @(posedge clk);
    inst_valid_i <= 1'b1;
    pc_i         <= pc;
    instr_i      <= ins;
    flush_i      <= do_flush;
    wb_en_i      <= do_wb;
    wb_idx_i     <= widx;
    wb_data_i    <= wdata;
    @(posedge clk);
    inst_valid_i <= 1'b0;
    flush_i      <= 1'b0;
    wb_en_i      <= 1'b0;
    if (do_wb && widx != 5'd0) begin
      shadow[widx] = wdata;
    end
    @(negedge clk);
  endtask

  task automatic run(input logic [31:0] ins, input logic [31:0] pc);
    issue(ins, pc, 1'b0, 1'b0, 5'd0, 32'd0);
  endtask

  task automatic expect_wb(input logic [31:0] exp, input logic [4:0] rd);
    check("alu_result_o", exp, alu_result_o);
    check("rd_idx_o", 32'(rd), 32'(rd_idx_o));
    check_bit("wb_en_o", 1'b1, wb_en_o);
    check_bit("ex_valid_o", 1'b1, ex_valid_o);
    check_bit("br_taken_o", 1'b0, br_taken_o);
    check_bit("trap_o", 1'b0, trap_o);
  endtask

  task automatic expect_jump(input logic [31:0] link, input logic [31:0] tgt,
                             input logic [4:0] rd);
    check("alu_result_o", link, alu_result_o);
    check("target_o", tgt, target_o);
    check("rd_idx_o", 32'(rd), 32'(rd_idx_o));
    check_bit("br_taken_o", 1'b1, br_taken_o);
    check_bit("wb_en_o", 1'b1, wb_en_o);
  endtask

  task automatic test_reset_state();
    @(negedge clk);
    check_bit("ex_valid_o", 1'b0, ex_valid_o);
    check_bit("wb_en_o", 1'b0, wb_en_o);
    check_bit("br_taken_o", 1'b0, br_taken_o);
    check_bit("trap_o", 1'b0, trap_o);
    end_test("reset state");
  endtask

  task automatic test_alu_ops();
    logic [2:0]  f3;
    logic        alt;
    logic [11:0] imm;
    logic [31:0] pc;
    logic [31:0] r;
    for (int k = 0; k < 10; k++) begin
      f3  = (k < 8) ? k[2:0] : ((k == 8) ? 3'd0 : 3'd5);
      alt = (k >= 8);
      write_reg(5'd5, next_rand());
      write_reg(5'd6, next_rand());
      pc = next_rand() & 32'hffff_fffc;
      run(enc_r(alt ? 7'h20 : 7'h00, 5'd6, 5'd5, f3, 5'd7, opc_op), pc);
      expect_wb(alu_ref(f3, alt, shadow[5], shadow[6]), 5'd7);
    end
    // Immediate forms. The two right shifts share funct3 101.
    for (int k = 0; k < 9; k++) begin
      f3  = (k < 8) ? k[2:0] : 3'd5;
      alt = (k == 8);
      r   = next_rand();
      imm = r[11:0];
      if (f3 == 3'd1 || f3 == 3'd5) begin
        imm = {alt ? 7'h20 : 7'h00, r[4:0]};
      end
      write_reg(5'd5, next_rand());
      pc = next_rand() & 32'hffff_fffc;
      run(enc_r(imm[11:5], imm[4:0], 5'd5, f3, 5'd8, opc_op_imm), pc);
      expect_wb(alu_ref(f3, alt, shadow[5], sext12(imm)), 5'd8);
    end
    // rs2 is written in the same cycle as the read.
    write_reg(5'd5, next_rand());
    r = next_rand();
    issue(enc_r(7'h00, 5'd6, 5'd5, 3'd0, 5'd9, opc_op), pc, 1'b0, 1'b1, 5'd6, r);
    expect_wb(shadow[5] + shadow[6], 5'd9);
    issue(enc_r(7'h00, 5'd0, 5'd5, 3'd0, 5'd10, opc_op), pc, 1'b0, 1'b1, 5'd0, next_rand());
    expect_wb(shadow[5], 5'd10);
    end_test("alu ops");
  endtask

  task automatic test_upper();
    logic [19:0] up;
    logic [31:0] pc;
    logic [31:0] r;
    r  = next_rand();
    up = r[31:12];
    pc = next_rand() & 32'hffff_fffc;
    run({up, 5'd11, opc_lui}, pc);
    expect_wb({up, 12'h000}, 5'd11);
    r  = next_rand();
    up = r[19:0];
    pc = next_rand() & 32'hffff_fffc;
    run({up, 5'd12, opc_auipc}, pc);
    expect_wb(pc + {up, 12'h000}, 5'd12);
    end_test("lui and auipc");
  endtask

  task automatic test_branches();
    logic [2:0]  f3;
    logic [12:0] imm;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] pc;
    logic [31:0] r;
    // Equal operands, then a negative against a positive both ways round.
    for (int p = 0; p < 3; p++) begin
      case (p)
        0: begin
          a = next_rand();
          b = a;
        end
        1: begin
          a = 32'h8000_0000 | next_rand();
          b = 32'h7fff_ffff & next_rand();
        end
        default: begin
          a = 32'h7fff_ffff & next_rand();
          b = 32'h8000_0000 | next_rand();
        end
      endcase
      write_reg(5'd11, a);
      write_reg(5'd12, b);
      for (int k = 0; k < 6; k++) begin
        f3  = (k < 2) ? k[2:0] : k[2:0] + 3'd2;
        r   = next_rand();
        imm = {r[12:1], 1'b0};
        pc  = next_rand() & 32'hffff_fffc;
        run(enc_b(imm, 5'd12, 5'd11, f3), pc);
        check_bit("br_taken_o", br_ref(f3, shadow[11], shadow[12]), br_taken_o);
        check("target_o", pc + sext13(imm), target_o);
        check_bit("wb_en_o", 1'b0, wb_en_o);
        check_bit("ex_valid_o", 1'b1, ex_valid_o);
      end
    end
    end_test("branches");
  endtask

  task automatic test_jumps();
    logic [20:0] jimm;
    logic [11:0] iimm;
    logic [31:0] base;
    logic [31:0] pc;
    logic [31:0] r;
    r    = next_rand();
    jimm = {r[20:1], 1'b0};
    pc   = next_rand() & 32'hffff_fffc;
    run(enc_j(jimm, 5'd1), pc);
    expect_jump(pc + 32'd4, pc + sext21(jimm), 5'd1);
    // The base is made odd against the offset so the cleared bit 0 shows.
    r    = next_rand();
    iimm = r[11:0];
    base = next_rand();
    if (((base + sext12(iimm)) & 32'd1) == 32'd0) begin
      base = base ^ 32'd1;
    end
    write_reg(5'd13, base);
    run(enc_r(iimm[11:5], iimm[4:0], 5'd13, 3'd0, 5'd2, opc_jalr), pc);
    expect_jump(pc + 32'd4, (shadow[13] + sext12(iimm)) & 32'hffff_fffe, 5'd2);
    end_test("jal and jalr");
  endtask

  task automatic test_stall_flush();
    logic [31:0] held;
    logic [31:0] pc;
    write_reg(5'd5, next_rand());
    write_reg(5'd6, next_rand());
    pc = next_rand() & 32'hffff_fffc;
    @(posedge clk);
    inst_valid_i <= 1'b1;
    pc_i         <= pc;
    instr_i      <= enc_r(7'h00, 5'd6, 5'd5, 3'd4, 5'd14, opc_op);
    @(posedge clk);
    inst_valid_i <= 1'b0;
    stall_i      <= 1'b1;
    @(negedge clk);
    held = shadow[5] ^ shadow[6];
    expect_wb(held, 5'd14);
    repeat (4) begin
      @(posedge clk);
      @(negedge clk);
      expect_wb(held, 5'd14);
    end
    // A jump flushed on entry must leave no trace on the control outputs.
    @(posedge clk);
    stall_i      <= 1'b0;
    flush_i      <= 1'b1;
    inst_valid_i <= 1'b1;
    instr_i      <= enc_j(21'h0_0100, 5'd1);
    @(posedge clk);
    flush_i      <= 1'b0;
    inst_valid_i <= 1'b0;
    @(negedge clk);
    check_bit("ex_valid_o", 1'b0, ex_valid_o);
    check_bit("wb_en_o", 1'b0, wb_en_o);
    check_bit("br_taken_o", 1'b0, br_taken_o);
    check_bit("trap_o", 1'b0, trap_o);
    end_test("stall and flush");
  endtask

  task automatic test_trap();
    run(enc_r(7'h00, 5'd6, 5'd5, 3'd2, 5'd15, opc_load), 32'h0000_0400);
    check_bit("trap_o", 1'b1, trap_o);
    check_bit("wb_en_o", 1'b0, wb_en_o);
    check_bit("br_taken_o", 1'b0, br_taken_o);
    check_bit("ex_valid_o", 1'b1, ex_valid_o);
    end_test("unknown opcode");
  endtask

  initial begin
    #(timeout_ns);
    $display("Watchdog expired after %0d ns with the tests still running", timeout_ns);
    $display("*** FAILED ***");
    $finish;
  end

  initial begin
    lcg_state    = 32'hbc18_417b;
    test_errs    = 0;
    tests_passed = 0;
    tests_failed = 0;
    for (int i = 0; i < 32; i++) begin
      shadow[i] = '0;
    end
    // A jump sits on the inputs through reset, so a register that ignored reset would show it.
    reset_i      <= 1'b1;
    inst_valid_i <= 1'b1;
    pc_i         <= '0;
    instr_i      <= enc_j(21'h0_0010, 5'd1);
    stall_i      <= 1'b0;
    flush_i      <= 1'b0;
    wb_en_i      <= 1'b0;
    wb_idx_i     <= '0;
    wb_data_i    <= '0;
    repeat (4) @(posedge clk);
    reset_i      <= 1'b0;
    inst_valid_i <= 1'b0;
    instr_i      <= '0;
    test_reset_state();
    test_alu_ops();
    test_upper();
    test_branches();
    test_jumps();
    test_stall_flush();
    test_trap();
    $display("Summary: %0d tests ok, %0d tests with mismatches", tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

//--- all.f
+incdir+logic
logic/rv_pkg.sv
logic/id_ex_if.sv
logic/reg_file.sv
logic/inst_decoder.sv
logic/ex_reg.sv
logic/ex_unit.sv
logic/id_ex_top.sv
dv/id_ex_tb.sv

//--- build.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it, and scans the log for the fail message.

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
  echo "Cannot enter the project root"
  exit 1
fi

log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
  --top-module id_ex_tb -f all.f -o id_ex_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/id_ex_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q '\*\*\* FAILED \*\*\*' "$log"; then
  exit 1
fi
exit 0
